// File: logic/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// datapath width of the execute stage
`define EXEC_DATA_WIDTH 32

// byte address width of the program counter
`define EXEC_PC_WIDTH 18

// cycles from multiply issue to the product on alu_result
`define EXEC_MUL_CYCLES 3

// the timer must hold EXEC_MUL_CYCLES minus one
`define EXEC_MUL_COUNT_WIDTH 2

`endif

// File: logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

	typedef enum logic [3:0]
	{
		ALU_ADD       = 4'd0,  // a + b + carry_in
		ALU_AND       = 4'd1,
		ALU_OR        = 4'd2,
		ALU_XOR       = 4'd3,
		ALU_SHR_ARITH = 4'd4,  // sign bit shifted in
		ALU_SHR_LOGIC = 4'd5,  // zero shifted in
		ALU_SHR_CARRY = 4'd6,  // carry shifted in
		ALU_SEXT8     = 4'd7,
		ALU_SEXT16    = 4'd8,
		ALU_MUL       = 4'd9,  // multicycle
		ALU_CMP       = 4'd10, // signed compare, msb fixed up in top
		ALU_CMPU      = 4'd11  // unsigned compare, msb from comparator
	} alu_fns_t;

	typedef enum logic [1:0]
	{
		SEL_A_REG     = 2'd0,
		SEL_A_REG_BAR = 2'd1,
		SEL_A_PC      = 2'd2, // zero extended pc
		SEL_A_ZERO    = 2'd3
	} alu_a_sel_t;

	typedef enum logic [1:0]
	{
		SEL_B_REG     = 2'd0,
		SEL_B_IMM     = 2'd1,
		SEL_B_REG_BAR = 2'd2,
		SEL_B_IMM_BAR = 2'd3
	} alu_b_sel_t;

	typedef enum logic [1:0]
	{
		SEL_C_ZERO  = 2'd0,
		SEL_C_ONE   = 2'd1,
		SEL_C_CARRY = 2'd2  // carry bit of the status register
	} alu_c_sel_t;

	typedef enum logic [2:0]
	{
		CMP_EQ     = 3'd0, // reg_a against zero
		CMP_NE     = 3'd1,
		CMP_LT     = 3'd2,
		CMP_LE     = 3'd3,
		CMP_GT     = 3'd4,
		CMP_GE     = 3'd5,
		CMP_GTU    = 3'd6, // reg_a > reg_b unsigned
		CMP_ALWAYS = 3'd7
	} cmp_fns_t;

	typedef enum logic [1:0]
	{
		SEQ_IDLE     = 2'd0,
		SEQ_MEM_WAIT = 2'd1,
		SEQ_MUL_WAIT = 2'd2
	} seq_state_t;

endpackage

`default_nettype wire

// File: logic/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_defines.svh"

module exec_alu
	import exec_pkg::*;
(
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  wire logic [`EXEC_DATA_WIDTH-1:0] alu_a,
	input  wire logic [`EXEC_DATA_WIDTH-1:0] alu_b,
	input  wire logic                        carry_in,
	input  wire alu_fns_t                    alu_fns,
	input  wire logic                        mul_start,
	output logic      [`EXEC_DATA_WIDTH-1:0] result,
	output logic                             carry_out,
	output logic      [`EXEC_DATA_WIDTH-1:0] sum
);

	localparam int DW = `EXEC_DATA_WIDTH;

	logic [DW:0]   sum_full;   // extra bit holds the carry out
	logic [DW-1:0] mul_a_q;    // operands held for the whole multiply
	logic [DW-1:0] mul_b_q;
	logic [DW-1:0] mul_prod;   // low half of the product only

	// adder shared by add, compare, branch target and memory address
	assign sum_full  = {1'b0, alu_a} + {1'b0, alu_b} + {{DW{1'b0}}, carry_in};
	assign sum       = sum_full[DW-1:0];
	assign carry_out = sum_full[DW];

	// operands captured on mul_start and stable until completion
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			mul_a_q <= '0;
			mul_b_q <= '0;
		end
		else if (mul_start)
		begin
			mul_a_q <= alu_a;
			mul_b_q <= alu_b;
		end
	end

	// multicycle path from mul_a_q/mul_b_q, EXEC_MUL_CYCLES cycles allowed
	assign mul_prod = mul_a_q * mul_b_q;

	always_comb
	begin
		result = sum; // add, cmp and cmpu
		case (alu_fns)
			ALU_AND:
				result = alu_a & alu_b;
			ALU_OR:
				result = alu_a | alu_b;
			ALU_XOR:
				result = alu_a ^ alu_b;
			ALU_SHR_ARITH:
				result = {alu_a[DW-1], alu_a[DW-1:1]};
			ALU_SHR_LOGIC:
				result = {1'b0, alu_a[DW-1:1]};
			ALU_SHR_CARRY:
				result = {carry_in, alu_a[DW-1:1]}; // rotate through carry
			ALU_SEXT8:
				result = {{(DW-8){alu_a[7]}}, alu_a[7:0]};
			ALU_SEXT16:
				result = {{(DW-16){alu_a[15]}}, alu_a[15:0]};
			ALU_MUL:
				result = mul_prod;
			default:
				result = sum;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/exec_mul_timer.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_defines.svh"

module exec_mul_timer
(
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic stall,
	input  wire logic mul_start,
	output logic      mul_last
);

	localparam int CW = `EXEC_MUL_COUNT_WIDTH;

	logic [CW-1:0] count;   // cycles left before the product is ready
	logic          running; // a multiply is in flight

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			count   <= '0;
			running <= 1'b0;
		end
		else if (mul_start)
		begin
			count   <= CW'(`EXEC_MUL_CYCLES - 1); // issue cycle counts as one
			running <= 1'b1;
		end
		else if (running && !stall)
		begin
			if (count == '0)
				running <= 1'b0; // product taken this cycle
			else
				count <= count - 1'b1;
		end
	end

	// held while stalled so the sequencer sees it once stall drops
	assign mul_last = running && (count == '0);

endmodule

`default_nettype wire

// File: logic/exec_compare.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_defines.svh"

module exec_compare
	import exec_pkg::*;
(
	input  wire logic [`EXEC_DATA_WIDTH-1:0] reg_a,
	input  wire logic [`EXEC_DATA_WIDTH-1:0] reg_b,
	input  wire cmp_fns_t                    cmp_fns,
	output logic                             cond
);

	localparam int DW = `EXEC_DATA_WIDTH;

	logic is_zero; // reg_a equals zero
	logic is_neg;  // reg_a sign bit

	assign is_zero = (reg_a == '0);
	assign is_neg  = reg_a[DW-1];

	always_comb
	begin
		cond = 1'b0;
		case (cmp_fns)
			CMP_EQ:     cond = is_zero;
			CMP_NE:     cond = !is_zero;
			CMP_LT:     cond = is_neg;
			CMP_LE:     cond = is_neg || is_zero;
			CMP_GT:     cond = !is_neg && !is_zero;
			CMP_GE:     cond = !is_neg;
			CMP_GTU:    cond = (reg_a > reg_b); // unsigned, also feeds cmpu
			CMP_ALWAYS: cond = 1'b1;            // unconditional branch
			default:    cond = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/exec_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module exec_sequencer
	import exec_pkg::*;
(
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     stall,
	input  wire logic     we_load,
	input  wire logic     we_store,
	input  wire alu_fns_t alu_fns,
	input  wire logic     dmem_done,
	input  wire logic     mul_last,
	output logic          dmem_re,
	output logic          dmem_we,
	output logic          mul_start,
	output logic          we_regfile,
	output logic          instr_complete
);

	seq_state_t state;
	seq_state_t next_state;
	logic       is_load;      // pending access is a load
	logic       done_pending; // dmem_done arrived while stalled
	logic       issue_mem;    // memory request goes out this cycle
	logic       mem_finish;

	assign issue_mem  = (state == SEQ_IDLE) && !stall && (we_load || we_store);
	assign mem_finish = dmem_done || done_pending;

	always_comb
	begin
		next_state     = state;
		dmem_re        = 1'b0;
		dmem_we        = 1'b0;
		mul_start      = 1'b0;
		we_regfile     = 1'b0;
		instr_complete = 1'b0;
		if (!stall) // stall blocks every strobe and completion
		begin
			case (state)
				SEQ_IDLE:
					if (we_load || we_store)
					begin
						dmem_re    = we_load;
						dmem_we    = we_store;
						next_state = SEQ_MEM_WAIT;
					end
					else if (alu_fns == ALU_MUL)
					begin
						mul_start  = 1'b1;
						next_state = SEQ_MUL_WAIT;
					end
					else
						instr_complete = 1'b1; // single cycle op
				SEQ_MEM_WAIT:
					if (mem_finish)
					begin
						instr_complete = 1'b1;
						we_regfile     = is_load; // stores write nothing back
						next_state     = SEQ_IDLE;
					end
				SEQ_MUL_WAIT:
					if (mul_last)
					begin
						instr_complete = 1'b1;
						we_regfile     = 1'b1;
						next_state     = SEQ_IDLE;
					end
				default:
					next_state = SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state        <= SEQ_IDLE;
			is_load      <= 1'b0;
			done_pending <= 1'b0;
		end
		else
		begin
			if (!stall)
				state <= next_state; // frozen under stall
			if (issue_mem)
				is_load <= we_load;
			// memory pulse is one cycle, keep it until stall drops
			if ((state == SEQ_MEM_WAIT) && stall && dmem_done)
				done_pending <= 1'b1;
			else if (!stall)
				done_pending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_defines.svh"

module exec_stage
	import exec_pkg::*;
(
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  wire logic                        stall,
	input  wire logic [`EXEC_DATA_WIDTH-1:0] immediate,
	input  wire logic [`EXEC_PC_WIDTH-1:0]   pc_exe,
	input  wire alu_a_sel_t                  alu_a_sel,
	input  wire alu_b_sel_t                  alu_b_sel,
	input  wire alu_c_sel_t                  alu_c_sel,
	input  wire alu_fns_t                    alu_fns,
	input  wire cmp_fns_t                    cmp_fns,
	input  wire logic                        we_load,
	input  wire logic                        we_store,
	input  wire logic                        update_carry,
	input  wire logic                        branch_instr,
	input  wire logic [`EXEC_DATA_WIDTH-1:0] reg_a,
	input  wire logic [`EXEC_DATA_WIDTH-1:0] reg_b,
	input  wire logic [`EXEC_DATA_WIDTH-1:0] reg_d,
	input  wire logic                        dmem_done,
	output logic      [`EXEC_DATA_WIDTH-1:0] alu_result,
	output logic      [`EXEC_PC_WIDTH-1:0]   pc_branch,
	output logic                             branch_taken,
	output logic                             we_regfile,
	output logic      [`EXEC_DATA_WIDTH-1:0] dmem_addr,
	output logic      [`EXEC_DATA_WIDTH-1:0] dmem_data_out,
	output logic                             dmem_re,
	output logic                             dmem_we,
	output logic                             instr_complete
);

	localparam int DW = `EXEC_DATA_WIDTH;
	localparam int PW = `EXEC_PC_WIDTH;

	logic [DW-1:0] extended_pc;  // pc padded with zeros
	logic [DW-1:0] alu_a;
	logic [DW-1:0] alu_b;
	logic          carry_in;
	logic          carry_q;      // carry bit of the status register
	logic          carry_out;
	logic [DW-1:0] alu_out;      // alu result before msb fix-up
	logic [DW-1:0] sum;
	logic          compare_out;
	logic          msb_signed;   // signed compare result bit
	logic          is_shift;
	logic          mul_start;
	logic          mul_last;

	assign extended_pc = {{(DW-PW){1'b0}}, pc_exe};

	always_comb
	begin
		case (alu_a_sel)
			SEL_A_REG:     alu_a = reg_a;
			SEL_A_REG_BAR: alu_a = ~reg_a; // subtract and compare
			SEL_A_PC:      alu_a = extended_pc;
			default:       alu_a = '0;
		endcase
	end

	always_comb
	begin
		case (alu_b_sel)
			SEL_B_REG:     alu_b = reg_b;
			SEL_B_IMM:     alu_b = immediate;
			SEL_B_REG_BAR: alu_b = ~reg_b;
			default:       alu_b = ~immediate;
		endcase
	end

	always_comb
	begin
		case (alu_c_sel)
			SEL_C_ONE:   carry_in = 1'b1;
			SEL_C_CARRY: carry_in = carry_q;
			default:     carry_in = 1'b0;
		endcase
	end

	assign is_shift = (alu_fns == ALU_SHR_ARITH) || (alu_fns == ALU_SHR_LOGIC) ||
		(alu_fns == ALU_SHR_CARRY);

	// carry only moves on unstalled add or shift
	always_ff @(posedge clock)
	begin
		if (reset)
			carry_q <= 1'b0;
		else if (!stall)
		begin
			if ((alu_fns == ALU_ADD) && update_carry)
				carry_q <= carry_out;
			else if (is_shift)
				carry_q <= alu_a[0]; // bit shifted out
		end
	end

	// differing signs decide alone, equal signs use the difference
	assign msb_signed = (reg_a[DW-1] != reg_b[DW-1]) ? reg_a[DW-1] : sum[DW-1];

	always_comb
	begin
		alu_result = alu_out;
		if (alu_fns == ALU_CMPU)
			alu_result[DW-1] = compare_out;
		else if (alu_fns == ALU_CMP)
			alu_result[DW-1] = msb_signed;
	end

	assign branch_taken  = branch_instr && compare_out;
	assign pc_branch     = sum[PW-1:0]; // target from the adder
	assign dmem_addr     = sum;
	assign dmem_data_out = reg_d;

	exec_alu u_alu
	(
		.clock     (clock),
		.reset     (reset),
		.alu_a     (alu_a),
		.alu_b     (alu_b),
		.carry_in  (carry_in),
		.alu_fns   (alu_fns),
		.mul_start (mul_start),
		.result    (alu_out),
		.carry_out (carry_out),
		.sum       (sum)
	);

	exec_compare u_compare
	(
		.reg_a   (reg_a),
		.reg_b   (reg_b),
		.cmp_fns (cmp_fns),
		.cond    (compare_out)
	);

	exec_sequencer u_sequencer
	(
		.clock          (clock),
		.reset          (reset),
		.stall          (stall),
		.we_load        (we_load),
		.we_store       (we_store),
		.alu_fns        (alu_fns),
		.dmem_done      (dmem_done),
		.mul_last       (mul_last),
		.dmem_re        (dmem_re),
		.dmem_we        (dmem_we),
		.mul_start      (mul_start),
		.we_regfile     (we_regfile),
		.instr_complete (instr_complete)
	);

	exec_mul_timer u_mul_timer
	(
		.clock     (clock),
		.reset     (reset),
		.stall     (stall),
		.mul_start (mul_start),
		.mul_last  (mul_last)
	);

endmodule

`default_nettype wire

// File: verif/exec_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_checker
(
	input wire logic clock,
	input wire logic reset,
	input wire logic stall,
	input wire logic dmem_re,
	input wire logic dmem_we,
	input wire logic mul_start,
	input wire logic we_regfile,
	input wire logic instr_complete
);

	int fail_count = 0; // failed assertions, watched by the testbench

	// memory requests are single-cycle pulses
	re_pulse: assert property (@(posedge clock) disable iff (reset) dmem_re |=> !dmem_re)
	else
	begin
		$error("dmem_re held for more than one cycle");
		fail_count++;
	end

	we_pulse: assert property (@(posedge clock) disable iff (reset) dmem_we |=> !dmem_we)
	else
	begin
		$error("dmem_we held for more than one cycle");
		fail_count++;
	end

	stall_quiet: assert property (@(posedge clock) disable iff (reset)
		stall |-> !(dmem_re || dmem_we || mul_start || we_regfile || instr_complete))
	else
	begin
		$error("strobe or completion seen while stalled");
		fail_count++;
	end

	write_with_done: assert property (@(posedge clock) disable iff (reset)
		we_regfile |-> instr_complete)
	else
	begin
		$error("we_regfile without instr_complete");
		fail_count++;
	end

	// inputs are idle during reset and one cycle after it
	reset_quiet: assert property (@(posedge clock)
		reset |=> !(dmem_re || dmem_we || mul_start || we_regfile))
	else
	begin
		$error("control output high in the cycle after reset");
		fail_count++;
	end

endmodule

bind exec_stage exec_stage_checker u_checker
(
	.clock          (clock),
	.reset          (reset),
	.stall          (stall),
	.dmem_re        (dmem_re),
	.dmem_we        (dmem_we),
	.mul_start      (mul_start), // internal sequencer strobe
	.we_regfile     (we_regfile),
	.instr_complete (instr_complete)
);

`default_nettype wire

// File: verif/exec_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "exec_defines.svh"

module exec_stage_tb;
	import exec_pkg::*;

	localparam int DW         = `EXEC_DATA_WIDTH;
	localparam int PW         = `EXEC_PC_WIDTH;
	localparam int LONG_LIMIT = 40; // cycles allowed for a multicycle op
	localparam int KIND_MUL   = 0;
	localparam int KIND_LOAD  = 1;
	localparam int KIND_STORE = 2;

	logic          clock;
	logic          reset;
	logic          stall;
	logic [DW-1:0] immediate;
	logic [PW-1:0] pc_exe;
	alu_a_sel_t    alu_a_sel;
	alu_b_sel_t    alu_b_sel;
	alu_c_sel_t    alu_c_sel;
	alu_fns_t      alu_fns;
	cmp_fns_t      cmp_fns;
	logic          we_load;
	logic          we_store;
	logic          update_carry;
	logic          branch_instr;
	logic [DW-1:0] reg_a;
	logic [DW-1:0] reg_b;
	logic [DW-1:0] reg_d;
	logic          dmem_done;
	logic [DW-1:0] alu_result;
	logic [PW-1:0] pc_branch;
	logic          branch_taken;
	logic          we_regfile;
	logic [DW-1:0] dmem_addr;
	logic [DW-1:0] dmem_data_out;
	logic          dmem_re;
	logic          dmem_we;
	logic          instr_complete;

	logic [31:0]   rng;         // xorshift state
	logic          model_carry; // expected status carry
	logic [DW-1:0] op_a;        // operands of the next instruction
	logic [DW-1:0] op_b;
	logic [DW-1:0] op_d;
	logic [DW-1:0] op_imm;
	logic [PW-1:0] op_pc;
	cmp_fns_t      op_cmp;
	logic          op_branch;
	logic          op_load;
	logic          op_store;

	exec_stage uut (.*);

	always #5 clock = ~clock; // 10 ns period

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// branch conditions as defined for the decode side
	function automatic logic model_cond(input cmp_fns_t c, input logic [DW-1:0] a,
		input logic [DW-1:0] b);
		case (c)
			CMP_EQ:  return a == '0;
			CMP_NE:  return a != '0;
			CMP_LT:  return $signed(a) < 0;
			CMP_LE:  return $signed(a) <= 0;
			CMP_GT:  return $signed(a) > 0;
			CMP_GE:  return $signed(a) >= 0;
			CMP_GTU: return a > b; // unsigned
			default: return 1'b1;
		endcase
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [DW-1:0] got,
		input logic [DW-1:0] expected);
		assert (got === expected)
		else
			stop_on_error($sformatf("Mismatch at time %0t: %s is %h, expected %h",
				$time, name, got, expected));
	endtask

	task automatic apply_inputs(input alu_fns_t fn, input alu_a_sel_t as, input alu_b_sel_t bs,
		input alu_c_sel_t cs, input logic upd);
		alu_fns      = fn;
		alu_a_sel    = as;
		alu_b_sel    = bs;
		alu_c_sel    = cs;
		update_carry = upd;
		cmp_fns      = op_cmp;
		branch_instr = op_branch;
		reg_a        = op_a;
		reg_b        = op_b;
		reg_d        = op_d;
		immediate    = op_imm;
		pc_exe       = op_pc;
		we_load      = op_load;
		we_store     = op_store;
		dmem_done    = 1'b0; // memory answers only when told
	endtask

	task randomize_ops();
		logic [31:0] r;
		op_a      = next_rand();
		op_b      = next_rand();
		op_imm    = next_rand();
		op_d      = next_rand();
		r         = next_rand();
		op_pc     = r[PW-1:0];
		op_cmp    = cmp_fns_t'(r[30:28]);
		op_branch = r[31];
	endtask

	// one single-cycle op, held under stall for nstall cycles first
	task automatic single(input alu_fns_t fn, input alu_a_sel_t as, input alu_b_sel_t bs,
		input alu_c_sel_t cs, input logic upd, input int nstall);
		logic [DW-1:0] ma;
		logic [DW-1:0] mb;
		logic          mc;
		logic [DW:0]   full;
		logic [DW-1:0] expect_res;
		int            k;
		op_load  = 1'b0;
		op_store = 1'b0;
		for (k = 0; k <= nstall; k++)
		begin
			@(negedge clock);
			apply_inputs(fn, as, bs, cs, upd);
			stall = (k < nstall);
			#2; // outputs settled, well away from the edges
			case (as)
				SEL_A_REG:     ma = op_a;
				SEL_A_REG_BAR: ma = ~op_a;
				SEL_A_PC:      ma = DW'(op_pc);
				default:       ma = '0;
			endcase
			case (bs)
				SEL_B_REG:     mb = op_b;
				SEL_B_IMM:     mb = op_imm;
				SEL_B_REG_BAR: mb = ~op_b;
				default:       mb = ~op_imm;
			endcase
			mc   = (cs == SEL_C_ONE) || ((cs == SEL_C_CARRY) && model_carry);
			full = {1'b0, ma} + {1'b0, mb} + mc;
			case (fn)
				ALU_AND:       expect_res = ma & mb;
				ALU_OR:        expect_res = ma | mb;
				ALU_XOR:       expect_res = ma ^ mb;
				ALU_SHR_ARITH: expect_res = $signed(ma) >>> 1;
				ALU_SHR_LOGIC: expect_res = ma >> 1;
				ALU_SHR_CARRY: expect_res = {mc, ma[DW-1:1]};
				ALU_SEXT8:     expect_res = DW'($signed(ma[7:0]));
				ALU_SEXT16:    expect_res = DW'($signed(ma[15:0]));
				default:       expect_res = full[DW-1:0];
			endcase
			if (fn == ALU_CMPU)
				expect_res[DW-1] = model_cond(op_cmp, op_a, op_b);
			else if (fn == ALU_CMP) // issued as a minus b, msb is the signed less-than
				expect_res[DW-1] = $signed(op_a) < $signed(op_b);
			check_value("alu_result", alu_result, expect_res);
			check_value("pc_branch", pc_branch, full[PW-1:0]);
			check_value("branch_taken", branch_taken,
				op_branch && model_cond(op_cmp, op_a, op_b));
			check_value("instr_complete", instr_complete, !stall);
			check_value("we_regfile", we_regfile, 1'b0);
			check_value("dmem_re", dmem_re, 1'b0);
			check_value("dmem_we", dmem_we, 1'b0);
			if (!stall)
			begin
				if ((fn == ALU_ADD) && upd)
					model_carry = full[DW];
				else if (fn inside {ALU_SHR_ARITH, ALU_SHR_LOGIC, ALU_SHR_CARRY})
					model_carry = ma[0]; // bit shifted out
			end
		end
	endtask

	// multiply, load or store with stall before issue and after it
	task automatic long_op(input int kind, input int pre, input int mid, input int delay);
		int            t;
		int            done_t;
		int            re_count;
		int            we_count;
		logic          stalled;
		logic          finished;
		logic [DW-1:0] product;
		op_load  = (kind == KIND_LOAD);
		op_store = (kind == KIND_STORE);
		product  = op_a * op_b; // low half only
		if (kind == KIND_MUL)
			done_t = pre + `EXEC_MUL_CYCLES + mid;
		else
			done_t = pre + ((delay > mid) ? delay : mid + 1); // late done waits out the stall
		t        = 0;
		re_count = 0;
		we_count = 0;
		finished = 1'b0;
		while (!finished)
		begin
			if (t > LONG_LIMIT)
				stop_on_error($sformatf("timeout waiting for instr_complete, op kind %0d", kind));
			@(negedge clock);
			apply_inputs((kind == KIND_MUL) ? ALU_MUL : ALU_ADD, SEL_A_REG,
				(kind == KIND_MUL) ? SEL_B_REG : SEL_B_IMM, SEL_C_ZERO, 1'b0);
			stalled   = (t < pre) || ((t > pre) && (t <= pre + mid));
			stall     = stalled;
			dmem_done = (kind != KIND_MUL) && (t == pre + delay);
			#2;
			re_count += dmem_re;
			we_count += dmem_we;
			if ((t == pre) && (kind != KIND_MUL))
			begin
				check_value("dmem_re", dmem_re, op_load);
				check_value("dmem_we", dmem_we, op_store);
				check_value("dmem_addr", dmem_addr, op_a + op_imm);
				check_value("dmem_data_out", dmem_data_out, op_d);
			end
			if (instr_complete)
			begin
				check_value("instr_complete cycle", t, done_t);
				check_value("we_regfile", we_regfile, kind != KIND_STORE);
				if (kind == KIND_MUL)
					check_value("alu_result", alu_result, product);
				finished = 1'b1;
			end
			else
				check_value("we_regfile", we_regfile, 1'b0);
			t++;
		end
		check_value("dmem_re pulse count", re_count, op_load);
		check_value("dmem_we pulse count", we_count, op_store);
	endtask

	task automatic compare_pair();
		single(ALU_CMP, SEL_A_REG, SEL_B_REG_BAR, SEL_C_ONE, 1'b0, 0);
		single(ALU_CMPU, SEL_A_REG, SEL_B_REG_BAR, SEL_C_ONE, 1'b0, 0);
	endtask

	always @(uut.u_checker.fail_count)
		if (uut.u_checker.fail_count != 0)
			stop_on_error("bound checker reported an assertion failure");

	initial
	begin
		logic [31:0] r;
		int          i;
		rng         = 32'd77;
		model_carry = 1'b0;
		clock       = 1'b0;
		reset       = 1'b1;
		stall       = 1'b0;
		op_a        = '0;
		op_b        = '0;
		op_d        = '0;
		op_imm      = '0;
		op_pc       = '0;
		op_cmp      = CMP_EQ;
		op_branch   = 1'b0;
		op_load     = 1'b0;
		op_store    = 1'b0;
		apply_inputs(ALU_ADD, SEL_A_REG, SEL_B_REG, SEL_C_ZERO, 1'b0);
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// add, logic, shifts and sign extension under random selects
		for (i = 0; i < 80; i++)
		begin
			randomize_ops();
			r = next_rand();
			single(alu_fns_t'(r[3:0] % 4'd9), alu_a_sel_t'(r[5:4]), alu_b_sel_t'(r[7:6]),
				alu_c_sel_t'(r[9:8] % 2'd3), r[10], 0);
		end
		op_a = '1;
		op_b = 32'd1;
		single(ALU_ADD, SEL_A_REG, SEL_B_REG, SEL_C_ZERO, 1'b1, 0); // carry out set
		op_imm = '0;
		single(ALU_ADD, SEL_A_ZERO, SEL_B_IMM, SEL_C_CARRY, 1'b0, 0); // reads it back
		op_a = 32'h0000_0004;
		single(ALU_SHR_CARRY, SEL_A_REG, SEL_B_REG, SEL_C_CARRY, 1'b0, 0);
		single(ALU_ADD, SEL_A_ZERO, SEL_B_IMM, SEL_C_CARRY, 1'b0, 0); // bit 0 moved to carry

		// compares and branches
		for (i = 0; i < 40; i++)
		begin
			randomize_ops();
			r = next_rand();
			if (r[0])
				op_cmp = CMP_GTU;
			single(r[0] ? ALU_CMPU : ALU_CMP, SEL_A_REG, SEL_B_REG_BAR, SEL_C_ONE, 1'b0, 0);
		end
		op_a      = 32'h8000_0010;
		op_b      = 32'hFFFF_FF00; // both negative
		op_cmp    = CMP_GTU;
		op_branch = 1'b1;
		compare_pair();
		op_a = 32'hFFFF_FF00;
		op_b = 32'h8000_0010;
		compare_pair();
		op_branch = 1'b0;
		op_cmp    = CMP_ALWAYS;
		single(ALU_ADD, SEL_A_PC, SEL_B_IMM, SEL_C_ZERO, 1'b0, 0); // not a branch

		for (i = 0; i < 6; i++)
		begin
			randomize_ops();
			long_op(KIND_MUL, 0, 0, 0);
		end
		for (i = 0; i < 12; i++)
		begin
			randomize_ops();
			r = next_rand();
			long_op(r[0] ? KIND_LOAD : KIND_STORE, 0, 0, 1 + r[3:1] % 5);
		end

		// back-pressure on each kind of op
		randomize_ops();
		long_op(KIND_MUL, 1, 2, 0);
		long_op(KIND_LOAD, 2, 3, 2); // done arrives while stalled
		long_op(KIND_STORE, 1, 1, 4);
		op_a = '0;
		op_b = '0;
		single(ALU_ADD, SEL_A_REG, SEL_B_REG, SEL_C_ZERO, 1'b1, 0); // carry cleared
		op_a = '1;
		op_b = 32'd1;
		single(ALU_ADD, SEL_A_REG, SEL_B_REG, SEL_C_CARRY, 1'b1, 3);
		op_imm = '0;
		single(ALU_ADD, SEL_A_ZERO, SEL_B_IMM, SEL_C_CARRY, 1'b0, 0);

		@(negedge clock);
		if (uut.u_checker.fail_count == 0)
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
			stop_on_error("bound checker reported an assertion failure");
	end

endmodule

`default_nettype wire

// File: exec_stage.f
+incdir+logic
logic/exec_pkg.sv
logic/exec_alu.sv
logic/exec_mul_timer.sv
logic/exec_compare.sv
logic/exec_sequencer.sv
logic/exec_stage.sv
verif/exec_stage_checker.sv
verif/exec_stage_tb.sv
